// ==== sources.f ====
source/rv_isa_pkg.sv
source/alu_pkg.sv
source/alu.sv
source/inst_decoder.sv
source/reg_file.sv
source/exec_core.sv
testbench/tb_exec_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_exec_core -f sources.f -o tb_sim \
  && { ./obj_dir/tb_sim > sim.log 2>&1; cat sim.log; } \
  || { echo "build failed"; exit 1; }
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; } \
  || grep -q "ALL TESTS PASSED" sim.log \
  || { echo "no result found in sim.log"; exit 1; }

// ==== testbench/tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core
  import rv_isa_pkg::*;
;

  logic            clk_i;
  logic            arst_n_i;
  logic            instr_valid_i;
  logic [31:0]     instr_i;
  logic            done_o;
  logic            branch_taken_o;
  logic            illegal_o;
  logic [XLEN-1:0] result_o;

  logic [63:0] shadow [32];   // reference register file
  logic [31:0] rng;

  exec_core i_dut (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .done_o         (done_o),
    .branch_taken_o (branch_taken_o),
    .illegal_o      (illegal_o),
    .result_o       (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw64(output logic [63:0] v);
    rng = xorshift(rng);
    v[63:32] = rng;
    rng = xorshift(rng);
    v[31:0] = rng;
  endtask

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    inst_u w;
    w.r_fmt.funct7 = f7;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = OPC_OP;
    return w;
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    inst_u w;
    w.i_fmt.imm12  = imm;
    w.i_fmt.rs1    = rs1;
    w.i_fmt.funct3 = f3;
    w.i_fmt.rd     = rd;
    w.i_fmt.opcode = OPC_OP_IMM;
    return w;
  endfunction

  // rd_bits lands where a normal word keeps rd
  function automatic logic [31:0] branch_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd_bits);
    inst_u w;
    w.b_fmt.imm12   = 1'b0;
    w.b_fmt.imm10_5 = 6'd0;
    w.b_fmt.rs2     = rs2;
    w.b_fmt.rs1     = rs1;
    w.b_fmt.funct3  = f3;
    w.b_fmt.imm4_1  = rd_bits[4:1];
    w.b_fmt.imm11   = rd_bits[0];
    w.b_fmt.opcode  = OPC_BRANCH;
    return w;
  endfunction

  // integer op by funct3 where alt picks sub or sra
  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    case (f3)
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << b[5:0];
      3'd2:    r = {64{$signed(a) < $signed(b)}};
      3'd3:    r = {64{a < b}};
      3'd4:    r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[5:0];   // kept apart so the shift stays signed
        end else begin
          r = a >> b[5:0];
        end
      end
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  task automatic model_exec(input logic [31:0] w, output logic [63:0] res, output logic taken,
                            output logic ill, output logic wr);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [2:0]  f3;
    logic        br;
    a   = shadow[w[19:15]];
    b   = shadow[w[24:20]];
    imm = {{52{w[31]}}, w[31:20]};
    f3  = w[14:12];
    br  = 1'b0;
    ill = 1'b0;
    taken = 1'b0;
    res = '0;
    case (w[6:0])
      OPC_OP: begin
        ill = !(w[31:25] == 7'd0 || (w[31:25] == F7_ALT && (f3 == 3'd0 || f3 == 3'd5)));
        res = alu_ref(f3, w[30], a, b);
      end
      OPC_OP_IMM: begin
        if (f3 == 3'd1) ill = (w[31:26] != 6'd0);
        if (f3 == 3'd5) ill = (w[31:26] != 6'd0) && (w[31:26] != 6'b010000);
        res = alu_ref(f3, w[30] && (f3 == 3'd5), a, imm);
      end
      OPC_BRANCH: begin
        br = 1'b1;
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = ($signed(a) < $signed(b));
          3'd5: taken = ($signed(a) >= $signed(b));
          3'd6: taken = (a < b);
          3'd7: taken = (a >= b);
          default: ill = 1'b1;
        endcase
        res = {64{taken}};
      end
      default: ill = 1'b1;
    endcase
    if (ill) begin
      res   = '0;
      taken = 1'b0;
    end
    wr = !ill && !br && (w[11:7] != 5'd0);
  endtask

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic issue_instr(input logic [31:0] word);
    int cnt;
    @(negedge clk_i);
    assert (!done_o) else
      fail_stop($sformatf("ERROR %0t ns: done_o stayed high longer than one cycle", $time));
    instr_i       = word;
    instr_valid_i = 1'b1;
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    cnt = 0;
    while (!done_o && cnt < 10) begin   // done should already be up
      @(negedge clk_i);
      cnt++;
    end
    if (!done_o) fail_stop($sformatf("timeout: done_o never rose for instruction %h", word));
    assert (cnt == 0) else
      fail_stop($sformatf("ERROR %0t ns: done_o came %0d cycles late", $time, cnt));
  endtask

  task automatic exec_check(input string name, input logic [31:0] word);
    logic [63:0] exp_res;
    logic        exp_taken;
    logic        exp_ill;
    logic        exp_wr;
    model_exec(word, exp_res, exp_taken, exp_ill, exp_wr);
    issue_instr(word);
    assert (result_o == exp_res) else
      fail_stop($sformatf("ERROR %0t ns: %s (%h) result %h, expected %h",
                          $time, name, word, result_o, exp_res));
    assert (branch_taken_o == exp_taken && illegal_o == exp_ill) else
      fail_stop($sformatf("ERROR %0t ns: %s (%h) taken/illegal %b%b, expected %b%b",
                          $time, name, word, branch_taken_o, illegal_o, exp_taken, exp_ill));
    if (exp_wr) shadow[word[11:7]] = exp_res;
  endtask

  // 9 bits followed by five rounds of shift 11 and add 11
  task automatic load_reg(input logic [4:0] rd, input logic [63:0] value);
    exec_check("addi", i_word({3'b000, value[63:55]}, 5'd0, F3_ADD_SUB, rd));
    for (int k = 4; k >= 0; k--) begin
      exec_check("slli", i_word(12'd11, rd, F3_SLL, rd));
      exec_check("addi", i_word({1'b0, value[k*11 +: 11]}, rd, F3_ADD_SUB, rd));
    end
  endtask

  task automatic check_reset_state();
    assert (!done_o && !branch_taken_o && !illegal_o && result_o == '0) else
      fail_stop($sformatf("ERROR %0t ns: outputs not idle after reset", $time));
    exec_check("add after reset", r_word(7'd0, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
  endtask

  task automatic arith_logic();
    logic [63:0] a;
    logic [63:0] b;
    for (int n = 0; n < 4; n++) begin
      draw64(a);
      draw64(b);
      if (n == 0) begin   // signed overflow
        a = 64'h7fff_ffff_ffff_ffff;
        b = 64'h1;
      end else if (n == 1) begin   // unsigned wrap
        a = '1;
        b = 64'h3;
      end
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      exec_check("add", r_word(7'd0, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
      exec_check("sub", r_word(F7_ALT, 5'd2, 5'd1, F3_ADD_SUB, 5'd4));
      exec_check("and", r_word(7'd0, 5'd2, 5'd1, F3_AND, 5'd5));
      exec_check("or", r_word(7'd0, 5'd2, 5'd1, F3_OR, 5'd6));
      exec_check("xor", r_word(7'd0, 5'd2, 5'd1, F3_XOR, 5'd7));
      exec_check("add readback", r_word(7'd0, 5'd4, 5'd3, F3_ADD_SUB, 5'd8));
      exec_check("xor readback", r_word(7'd0, 5'd6, 5'd5, F3_XOR, 5'd9));
      exec_check("sub readback", r_word(F7_ALT, 5'd1, 5'd7, F3_ADD_SUB, 5'd10));
    end
  endtask

  task automatic shift_ops();
    logic [63:0] v;
    logic [5:0]  amts [4];
    for (int s = 0; s < 2; s++) begin
      draw64(v);
      v[63] = (s == 1);
      amts = '{6'd0, 6'd1, 6'd63, v[13:8]};
      load_reg(5'd1, v);
      foreach (amts[j]) begin
        exec_check("addi shamt", i_word({6'd0, amts[j]}, 5'd0, F3_ADD_SUB, 5'd2));
        exec_check("sll", r_word(7'd0, 5'd2, 5'd1, F3_SLL, 5'd3));
        exec_check("srl", r_word(7'd0, 5'd2, 5'd1, F3_SR, 5'd4));
        exec_check("sra", r_word(F7_ALT, 5'd2, 5'd1, F3_SR, 5'd5));
        exec_check("slli", i_word({6'd0, amts[j]}, 5'd1, F3_SLL, 5'd6));
        exec_check("srli", i_word({6'd0, amts[j]}, 5'd1, F3_SR, 5'd7));
        exec_check("srai", i_word({6'b010000, amts[j]}, 5'd1, F3_SR, 5'd8));
        // top shamt+1 bits must copy the sign
        assert (!v[63] || ((~result_o) >> (63 - int'(amts[j]))) == 64'd0) else
          fail_stop($sformatf("ERROR %0t ns: srai by %0d did not fill with ones, got %h",
                              $time, amts[j], result_o));
      end
    end
  endtask

  task automatic compare_ops();
    logic [63:0] pa [4];
    logic [63:0] pb [4];
    logic [11:0] imms [3];
    draw64(pa[0]);
    pb[0] = pa[0];                               // equal
    pa[1] = 64'hffff_ffff_ffff_fff0;             // negative vs positive
    pb[1] = 64'h10;
    pa[2] = 64'h8000_0000_0000_0005;             // unsigned large
    pb[2] = 64'h5;
    pa[3] = 64'h5;
    pb[3] = '1;
    imms = '{12'hfff, 12'h005, 12'h800};
    foreach (pa[p]) begin
      load_reg(5'd1, pa[p]);
      load_reg(5'd2, pb[p]);
      exec_check("slt", r_word(7'd0, 5'd2, 5'd1, F3_SLT, 5'd3));
      exec_check("sltu", r_word(7'd0, 5'd2, 5'd1, F3_SLTU, 5'd4));
      exec_check("slt swapped", r_word(7'd0, 5'd1, 5'd2, F3_SLT, 5'd3));
      foreach (imms[m]) begin
        exec_check("slti", i_word(imms[m], 5'd1, F3_SLT, 5'd5));
        exec_check("sltiu", i_word(imms[m], 5'd1, F3_SLTU, 5'd6));
      end
    end
  endtask

  task automatic branch_ops();
    logic [63:0] pa [4];
    logic [63:0] pb [4];
    logic [63:0] marker;
    logic [2:0]  f3s [6];
    draw64(pa[0]);
    pb[0] = pa[0];
    pa[1] = 64'hffff_ffff_ffff_fff0;
    pb[1] = 64'h10;
    pa[2] = 64'h10;
    pb[2] = 64'hffff_ffff_ffff_fff0;
    draw64(pa[3]);
    draw64(pb[3]);
    draw64(marker);
    f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    load_reg(5'd19, marker);   // x19 sits under the rd bits of every branch
    foreach (pa[p]) begin
      load_reg(5'd1, pa[p]);
      load_reg(5'd2, pb[p]);
      foreach (f3s[q]) begin
        exec_check("branch", branch_word(5'd2, 5'd1, f3s[q], 5'd19));
        exec_check("read x19", r_word(7'd0, 5'd0, 5'd19, F3_ADD_SUB, 5'd20));
      end
    end
  endtask

  task automatic illegal_and_x0();
    logic [63:0] v;
    logic [31:0] bad;
    draw64(v);
    load_reg(5'd5, v);
    load_reg(5'd1, 64'h1234);
    bad = r_word(7'd0, 5'd2, 5'd1, F3_ADD_SUB, 5'd5);
    bad[6:0] = 7'b1111111;   // no such opcode
    exec_check("unknown opcode", bad);
    exec_check("read x5", r_word(7'd0, 5'd0, 5'd5, F3_ADD_SUB, 5'd6));
    exec_check("bad funct7", r_word(7'd1, 5'd2, 5'd1, F3_ADD_SUB, 5'd5));
    exec_check("bad srai", i_word({6'b000001, 6'd3}, 5'd1, F3_SR, 5'd5));
    exec_check("bad branch", branch_word(5'd2, 5'd1, 3'b010, 5'd5));
    exec_check("read x5", r_word(7'd0, 5'd0, 5'd5, F3_ADD_SUB, 5'd6));
    exec_check("addi x0", i_word(12'd123, 5'd0, F3_ADD_SUB, 5'd0));
    exec_check("read x0", r_word(7'd0, 5'd0, 5'd0, F3_ADD_SUB, 5'd7));
  endtask

  initial begin
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    rng           = 32'he178;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    check_reset_state();
    arith_logic();
    shift_ops();
    compare_ops();
    branch_ops();
    illegal_and_x0();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== source/exec_core.sv ====
`timescale 1ns/1ps

module exec_core
  import rv_isa_pkg::*;
  import alu_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            instr_valid_i,
  input  logic [31:0]     instr_i,
  output logic            done_o,
  output logic            branch_taken_o,
  output logic            illegal_o,
  output logic [XLEN-1:0] result_o
);

  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [ALUOP_LEN-1:0]  alu_op;
  logic [XLEN-1:0]       imm;
  logic                  use_imm;
  logic                  wr_en;
  logic                  is_branch;
  logic                  illegal;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       alu_b;
  logic [XLEN-1:0]       alu_out;
  logic                  compare_out;

  inst_decoder i_decoder (
    .instr_i     (instr_i),
    .rs1_addr_o  (rs1_addr),
    .rs2_addr_o  (rs2_addr),
    .rd_addr_o   (rd_addr),
    .alu_op_o    (alu_op),
    .imm_o       (imm),
    .use_imm_o   (use_imm),
    .wr_en_o     (wr_en),
    .is_branch_o (is_branch),
    .illegal_o   (illegal)
  );

  reg_file i_reg_file (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (instr_valid_i & wr_en),   // writes land on the strobe edge
    .rd_addr_i  (rd_addr),
    .rd_data_i  (alu_out)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  alu i_alu (
    .alu_a_i       (rs1_data),
    .alu_b_i       (alu_b),
    .alu_op_i      (alu_op),
    .alu_out_o     (alu_out),
    .compare_out_o (compare_out)
  );

  // outputs hold until the next strobe, done is a single pulse
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_o         <= 1'b0;
      branch_taken_o <= 1'b0;
      illegal_o      <= 1'b0;
      result_o       <= '0;
    end else begin
      done_o <= instr_valid_i;
      if (instr_valid_i) begin
        branch_taken_o <= is_branch & compare_out;
        illegal_o      <= illegal;
        result_o       <= illegal ? '0 : alu_out;
      end
    end
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
  import rv_isa_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [REG_ADDR_W-1:0] rs2_addr_i,
  output logic [XLEN-1:0]       rs1_data_o,
  output logic [XLEN-1:0]       rs2_data_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_i,
  input  logic [XLEN-1:0]       rd_data_i
);

  localparam int NUM_REGS = 1 << REG_ADDR_W;

  logic [XLEN-1:0] regs [NUM_REGS];

  // write port, x0 stays zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_addr_i != '0)) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // async reads
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder
  import rv_isa_pkg::*;
  import alu_pkg::*;
(
  input  inst_u                 instr_i,
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  output logic [REG_ADDR_W-1:0] rd_addr_o,
  output logic [ALUOP_LEN-1:0]  alu_op_o,
  output logic [XLEN-1:0]       imm_o,
  output logic                  use_imm_o,
  output logic                  wr_en_o,
  output logic                  is_branch_o,
  output logic                  illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [6:0] imm_f7;   // shift-immediate funct with shamt[5] dropped
  logic       branch;
  logic       illegal;

  // opcode, funct3 and register indices sit in the same bits in every view
  assign opcode = instr_i.r_fmt.opcode;
  assign funct3 = instr_i.r_fmt.funct3;
  assign funct7 = instr_i.r_fmt.funct7;
  assign imm_f7 = {instr_i.i_fmt.imm12[11:6], 1'b0};

  always_comb begin
    rs1_addr_o = instr_i.r_fmt.rs1;
    rs2_addr_o = instr_i.r_fmt.rs2;
    alu_op_o   = ALUOP_ADD;
    use_imm_o  = 1'b0;
    branch     = 1'b0;
    illegal    = 1'b0;
    case (opcode)
      OPC_OP: begin
        case (funct3)
          F3_ADD_SUB: alu_op_o = (funct7 == F7_ALT) ? ALUOP_SUB : ALUOP_ADD;
          F3_SLL:     alu_op_o = ALUOP_SLL;
          F3_SLT:     alu_op_o = ALUOP_SLT;
          F3_SLTU:    alu_op_o = ALUOP_SLTU;
          F3_XOR:     alu_op_o = ALUOP_XOR;
          F3_SR:      alu_op_o = (funct7 == F7_ALT) ? ALUOP_SRA : ALUOP_SRL;
          F3_OR:      alu_op_o = ALUOP_OR;
          default:    alu_op_o = ALUOP_AND;
        endcase
        if (funct7 == F7_ALT) begin
          illegal = (funct3 != F3_ADD_SUB) && (funct3 != F3_SR);
        end else begin
          illegal = (funct7 != 7'd0);
        end
      end
      OPC_OP_IMM: begin
        rs2_addr_o = '0;   // no rs2 field here
        use_imm_o  = 1'b1;
        case (funct3)
          F3_ADD_SUB: alu_op_o = ALUOP_ADD;
          F3_SLT:     alu_op_o = ALUOP_SLTI;
          F3_SLTU:    alu_op_o = ALUOP_SLTIU;
          F3_XOR:     alu_op_o = ALUOP_XOR;
          F3_OR:      alu_op_o = ALUOP_OR;
          F3_AND:     alu_op_o = ALUOP_AND;
          F3_SLL: begin
            alu_op_o = ALUOP_SLL;
            illegal  = (imm_f7 != 7'd0);
          end
          default: begin   // F3_SR
            alu_op_o = (imm_f7 == F7_ALT) ? ALUOP_SRA : ALUOP_SRL;
            illegal  = (imm_f7 != 7'd0) && (imm_f7 != F7_ALT);
          end
        endcase
      end
      OPC_BRANCH: begin
        branch = 1'b1;
        case (instr_i.b_fmt.funct3)
          F3_BEQ:  alu_op_o = ALUOP_BEQ;
          F3_BNE:  alu_op_o = ALUOP_BNE;
          F3_BLT:  alu_op_o = ALUOP_BLT;
          F3_BGE:  alu_op_o = ALUOP_BGE;
          F3_BLTU: alu_op_o = ALUOP_BLTU;
          F3_BGEU: alu_op_o = ALUOP_BGEU;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  assign rd_addr_o   = instr_i.r_fmt.rd;
  assign imm_o       = {{(XLEN-12){instr_i.i_fmt.imm12[11]}}, instr_i.i_fmt.imm12};
  assign is_branch_o = branch & ~illegal;
  assign illegal_o   = illegal;
  assign wr_en_o     = ~illegal & ~branch & (rd_addr_o != '0);   // x0 never written

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu
  import rv_isa_pkg::*;
  import alu_pkg::*;
(
  input  logic [XLEN-1:0]      alu_a_i,
  input  logic [XLEN-1:0]      alu_b_i,
  input  logic [ALUOP_LEN-1:0] alu_op_i,
  output logic [XLEN-1:0]      alu_out_o,
  output logic                 compare_out_o   // condition result, also for slt
);

  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] din);
    logic [XLEN-1:0] dout;
    for (int i = 0; i < XLEN; i++) begin
      dout[i] = din[XLEN-1-i];
    end
    return dout;
  endfunction

  // one-hot op decode
  logic op_add, op_xor, op_or, op_and, op_sll, op_srl, op_sra, op_sub;
  logic op_slt, op_sltu, op_slti, op_sltiu;
  logic op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu;

  assign op_add   = (alu_op_i == ALUOP_ADD);
  assign op_xor   = (alu_op_i == ALUOP_XOR);
  assign op_or    = (alu_op_i == ALUOP_OR);
  assign op_and   = (alu_op_i == ALUOP_AND);
  assign op_sll   = (alu_op_i == ALUOP_SLL);
  assign op_srl   = (alu_op_i == ALUOP_SRL);
  assign op_sra   = (alu_op_i == ALUOP_SRA);
  assign op_sub   = (alu_op_i == ALUOP_SUB);
  assign op_slt   = (alu_op_i == ALUOP_SLT);
  assign op_sltu  = (alu_op_i == ALUOP_SLTU);
  assign op_slti  = (alu_op_i == ALUOP_SLTI);
  assign op_sltiu = (alu_op_i == ALUOP_SLTIU);
  assign op_beq   = (alu_op_i == ALUOP_BEQ);
  assign op_bne   = (alu_op_i == ALUOP_BNE);
  assign op_blt   = (alu_op_i == ALUOP_BLT);
  assign op_bge   = (alu_op_i == ALUOP_BGE);
  assign op_bltu  = (alu_op_i == ALUOP_BLTU);
  assign op_bgeu  = (alu_op_i == ALUOP_BGEU);

  // shared adder, every compare is a subtract
  logic            is_cmp;
  logic            sub_op;
  logic [XLEN:0]   a_ext;
  logic [XLEN:0]   b_ext;
  logic [XLEN:0]   add_out;
  logic            carry_top;
  logic            is_zero;
  logic            of_flag;
  logic            lt_s;
  logic            lt_u;
  logic            cmp;

  assign is_cmp = op_slt | op_sltu | op_slti | op_sltiu |
                  op_beq | op_bne | op_blt | op_bge | op_bltu | op_bgeu;
  assign sub_op = op_sub | is_cmp;

  assign a_ext   = {alu_a_i[XLEN-1], alu_a_i};   // doubled sign bit
  assign b_ext   = {alu_b_i[XLEN-1], alu_b_i} ^ {(XLEN+1){sub_op}};
  assign add_out = a_ext + b_ext + (XLEN+1)'(sub_op);

  // carry into the doubled sign position is the carry out of bit XLEN-1
  assign carry_top = a_ext[XLEN] ^ b_ext[XLEN] ^ add_out[XLEN];
  assign is_zero   = (add_out[XLEN-1:0] == '0);
  assign of_flag   = add_out[XLEN] ^ add_out[XLEN-1];
  assign lt_s      = add_out[XLEN-1] ^ of_flag;   // sign xor overflow
  assign lt_u      = sub_op ^ carry_top;          // no carry means borrow

  assign cmp = ((op_slt | op_slti | op_blt) & lt_s) |
               ((op_sltu | op_sltiu | op_bltu) & lt_u) |
               (op_bge & ~lt_s) |
               (op_bgeu & ~lt_u) |
               (op_beq & is_zero) |
               (op_bne & ~is_zero);

  // shifter, right shifts go through the left shifter reversed
  logic               shift_right;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    sh_in;
  logic [XLEN-1:0]    sh_res;
  logic [XLEN-1:0]    srl_res;
  logic [XLEN-1:0]    sra_mask;
  logic [XLEN-1:0]    sra_res;

  assign shift_right = op_srl | op_sra;
  assign shamt       = alu_b_i[SHAMT_W-1:0];
  assign sh_in       = shift_right ? bit_rev(alu_a_i) : alu_a_i;
  assign sh_res      = sh_in << shamt;
  assign srl_res     = bit_rev(sh_res);
  assign sra_mask    = {XLEN{1'b1}} >> shamt;   // ones where data bits survive
  assign sra_res     = (srl_res & sra_mask) | ({XLEN{alu_a_i[XLEN-1]}} & ~sra_mask);

  // final select
  logic [XLEN-1:0] res;

  assign res = (op_add | op_sub) ? add_out[XLEN-1:0] :
               op_and            ? (alu_a_i & alu_b_i) :
               op_or             ? (alu_a_i | alu_b_i) :
               op_xor            ? (alu_a_i ^ alu_b_i) :
               op_sll            ? sh_res :
               op_srl            ? srl_res :
               op_sra            ? sra_res :
               '0;

  assign alu_out_o     = is_cmp ? {XLEN{cmp}} : res;   // compares give all ones or zeros
  assign compare_out_o = cmp;

endmodule

// ==== source/alu_pkg.sv ====
package alu_pkg;

  localparam int ALUOP_LEN = 5;

  // arithmetic and logic
  localparam logic [ALUOP_LEN-1:0] ALUOP_ADD = 5'd0;   // also the idle code
  localparam logic [ALUOP_LEN-1:0] ALUOP_XOR = 5'd1;
  localparam logic [ALUOP_LEN-1:0] ALUOP_OR  = 5'd2;
  localparam logic [ALUOP_LEN-1:0] ALUOP_AND = 5'd3;
  localparam logic [ALUOP_LEN-1:0] ALUOP_SLL = 5'd4;
  localparam logic [ALUOP_LEN-1:0] ALUOP_SRL = 5'd5;
  localparam logic [ALUOP_LEN-1:0] ALUOP_SRA = 5'd6;
  localparam logic [ALUOP_LEN-1:0] ALUOP_SUB = 5'd7;

  // set-less-than, register and immediate
  localparam logic [ALUOP_LEN-1:0] ALUOP_SLT   = 5'd8;
  localparam logic [ALUOP_LEN-1:0] ALUOP_SLTU  = 5'd9;
  localparam logic [ALUOP_LEN-1:0] ALUOP_SLTI  = 5'd10;
  localparam logic [ALUOP_LEN-1:0] ALUOP_SLTIU = 5'd11;

  // branch conditions
  localparam logic [ALUOP_LEN-1:0] ALUOP_BEQ  = 5'd12;
  localparam logic [ALUOP_LEN-1:0] ALUOP_BNE  = 5'd13;
  localparam logic [ALUOP_LEN-1:0] ALUOP_BLT  = 5'd14;
  localparam logic [ALUOP_LEN-1:0] ALUOP_BGE  = 5'd15;
  localparam logic [ALUOP_LEN-1:0] ALUOP_BLTU = 5'd16;
  localparam logic [ALUOP_LEN-1:0] ALUOP_BGEU = 5'd17;

endpackage

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 6;   // rv64 shifts reach 63

  // major opcodes handled by this slice
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;   // srl or sra by funct7
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_ALT = 7'b0100000;   // sub, sra

  // one instruction word, three readings of it
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r_fmt;
    struct packed {
      logic [11:0]           imm12;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i_fmt;
    struct packed {
      logic                  imm12;
      logic [5:0]            imm10_5;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [3:0]            imm4_1;
      logic                  imm11;
      logic [6:0]            opcode;
    } b_fmt;
  } inst_u;

endpackage
